// File: design/capture_pkg.sv
// ********************
// shared types for the sample capture block
// register addresses, capture states, write, config and FIFO entry structs
// ********************

package capture_pkg;

  localparam int SAMPLE_WIDTH = 16;
  localparam int ENTRY_WIDTH = 16 + SAMPLE_WIDTH; // index on top, sample below

  typedef enum logic [1:0] {
    ADDR_CONTROL   = 2'd0, // bit 0 starts a capture
    ADDR_THRESHOLD = 2'd1,
    ADDR_LENGTH    = 2'd2
  } reg_addr_e;

  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_CAPTURE = 2'd1,
    ST_DRAIN   = 2'd2  // one cycle to flush the final entry with last
  } capture_state_e;

  typedef struct packed {
    logic        valid;
    reg_addr_e   addr;
    logic [31:0] data;
  } reg_write_t;

  typedef struct packed {
    logic signed [SAMPLE_WIDTH-1:0] threshold;
    logic [15:0]                    length;  // input samples per capture
  } capture_cfg_t;

  typedef struct packed {
    logic                    last;
    logic [15:0]             index;
    logic [SAMPLE_WIDTH-1:0] sample;
  } capture_entry_t;

endpackage

// File: design/axis_if.sv
// ********************
// AXI-stream style interface
// data, valid, ready and last with master and slave modports
// ********************

`timescale 1ns/1ps

interface Axis_If #(
  parameter int DWIDTH = 32
);

  logic [DWIDTH-1:0] data;
  logic              valid;
  logic              ready;
  logic              last;

  modport Master (
    input  ready,
    output valid, data, last
  );

  modport Slave (
    input  valid, data, last,
    output ready
  );

endinterface

// File: design/capture_regs.sv
// ********************
// capture register block
// decodes writes into threshold and length, makes the start pulse
// ********************

`timescale 1ns/1ps

module capture_regs (
  input  logic                      clk,
  input  logic                      reset_valid,
  input  capture_pkg::reg_write_t   reg_wr,
  output capture_pkg::capture_cfg_t cfg,
  output logic                      start
);

  import capture_pkg::*;

  // one write per cycle, no back-pressure on this port
  always_ff @(posedge clk) begin
    if (reset_valid) begin
      cfg   <= '0;
      start <= 1'b0;
    end else begin
      start <= 1'b0; // pulse lasts a single cycle
      if (reg_wr.valid) begin
        case (reg_wr.addr)
          ADDR_CONTROL: begin
            start <= reg_wr.data[0];
          end
          ADDR_THRESHOLD: begin
            cfg.threshold <= reg_wr.data[SAMPLE_WIDTH-1:0];
          end
          ADDR_LENGTH: begin
            cfg.length <= reg_wr.data[15:0];
          end
          default: begin
            // unmapped address, write is ignored
          end
        endcase
      end
    end
  end

endmodule

// File: design/threshold_discriminator.sv
// ********************
// capture FSM and threshold compare
// keeps samples above the threshold, tags them with their index
// holds one kept entry back so the final write can carry last
// ********************

`timescale 1ns/1ps

module threshold_discriminator (
  input  logic                        clk,
  input  logic                        reset_valid,
  input  capture_pkg::capture_cfg_t   cfg,
  input  logic                        start,
  Axis_If.Slave                       s_axis,
  input  logic                        almost_full,
  output logic                        wr_en,
  output capture_pkg::capture_entry_t wr_entry,
  output logic                        busy
);

  import capture_pkg::*;

  capture_state_e state;
  logic [15:0]    index;      // input samples accepted so far in this capture
  logic           accept;
  logic           keep;
  logic           at_end;
  logic           pend_valid;
  capture_entry_t pend;       // kept entry waiting for its write

  // input is always taken unless the FIFO is close to full, even when idle
  assign s_axis.ready = ~almost_full;
  assign accept = s_axis.valid & s_axis.ready;
  assign keep = $signed(s_axis.data) > $signed(cfg.threshold);
  assign at_end = index == (cfg.length - 16'd1);
  assign busy = state != ST_IDLE;

  // a new kept sample pushes the older pending one into the FIFO
  always_comb begin
    wr_en = 1'b0;
    wr_entry = pend;
    if (state == ST_CAPTURE) begin
      wr_en = accept & keep & pend_valid;
    end else if (state == ST_DRAIN) begin
      wr_en = pend_valid;   // nothing kept means nothing written
      wr_entry.last = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_valid) begin
      state      <= ST_IDLE;
      index      <= '0;
      pend_valid <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_CAPTURE;
            index <= '0;
          end
        end
        ST_CAPTURE: begin
          // start pulses are ignored here
          if (accept) begin
            index <= index + 16'd1;
            if (keep) begin
              pend_valid <= 1'b1;
            end
            if (at_end) begin
              state <= ST_DRAIN;
            end
          end
        end
        ST_DRAIN: begin
          pend_valid <= 1'b0; // flushed this cycle
          state      <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // pending payload
  always_ff @(posedge clk) begin
    if ((state == ST_CAPTURE) && accept && keep) begin
      pend.last   <= 1'b0;
      pend.index  <= index;
      pend.sample <= s_axis.data;
    end
  end

endmodule

// File: design/sample_fifo.sv
// ********************
// synchronous FIFO of capture entries
// registered head drives the master stream, almost_full for the writer
// ********************

`timescale 1ns/1ps

module sample_fifo #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                        clk,
  input  logic                        reset_valid,
  input  logic                        wr_en,
  input  capture_pkg::capture_entry_t wr_entry,
  output logic                        almost_full,
  Axis_If.Master                      m_axis
);

  import capture_pkg::*;

  localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);
  localparam logic [PTR_WIDTH:0] AF_LEVEL = (PTR_WIDTH + 1)'(FIFO_DEPTH - 1);

  capture_entry_t       mem [FIFO_DEPTH];
  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [PTR_WIDTH:0]   count;     // entries in mem, head register not included
  logic                 out_valid;
  capture_entry_t       out_entry; // head of the queue
  logic                 pop;
  logic                 load;

  assign pop = out_valid & m_axis.ready;
  // refill the head when it is empty or leaving this cycle
  assign load = (count != '0) & (~out_valid | pop);
  assign almost_full = count >= AF_LEVEL; // at most one slot left

  assign m_axis.valid = out_valid;
  assign m_axis.data  = {out_entry.index, out_entry.sample};
  assign m_axis.last  = out_entry.last;

  always_ff @(posedge clk) begin
    if (reset_valid) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      out_valid <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, wraps by itself
      end
      if (load) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, load})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (load) begin
        out_valid <= 1'b1;
      end else if (pop) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_entry;
    end
    if (load) begin
      out_entry <= mem[rd_ptr];
    end
  end

endmodule

// File: design/sample_capture_top.sv
// ********************
// sample capture top level
// register block, discriminator and output FIFO
// ********************

`timescale 1ns/1ps

module sample_capture_top #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                    clk,
  input  logic                    reset_valid,
  input  capture_pkg::reg_write_t reg_wr,
  Axis_If.Slave                   s_axis,
  Axis_If.Master                  m_axis,
  output logic                    capture_busy
);

  import capture_pkg::*;

  capture_cfg_t   cfg;
  logic           start;
  logic           wr_en;
  capture_entry_t wr_entry;
  logic           almost_full;

  capture_regs regs0 (
    .clk         (clk),
    .reset_valid (reset_valid),
    .reg_wr      (reg_wr),
    .cfg         (cfg),
    .start       (start)
  );

  // input ready comes from here, following the FIFO fill level
  threshold_discriminator disc0 (
    .clk         (clk),
    .reset_valid (reset_valid),
    .cfg         (cfg),
    .start       (start),
    .s_axis      (s_axis),
    .almost_full (almost_full),
    .wr_en       (wr_en),
    .wr_entry    (wr_entry),
    .busy        (capture_busy)
  );

  sample_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) fifo0 (
    .clk         (clk),
    .reset_valid (reset_valid),
    .wr_en       (wr_en),
    .wr_entry    (wr_entry),
    .almost_full (almost_full),
    .m_axis      (m_axis)
  );

endmodule

// File: tb/axis_driver.sv
// ********************
// stream driver for the sample input
// sends sample queues with or without random valid gaps
// ********************

`timescale 1ns/1ps

module axis_driver #(
  parameter int WAIT_LIMIT = 2000
) (
  input  logic   clk,
  Axis_If.Master axis
);

  import capture_pkg::*;

  initial begin
    axis.valid = 1'b0;
    axis.data  = '0;
    axis.last  = 1'b0;
  end

  // called on a falling edge, returns on the falling edge after the transfer
  task automatic send_beat(input logic [SAMPLE_WIDTH-1:0] sample, input bit last,
                           output bit ok);
    int waited;
    waited = 0;
    ok = 1'b1;
    axis.valid = 1'b1;
    axis.data  = sample;
    axis.last  = last;
    while (!axis.ready && ok) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        ok = 1'b0; // sink never took the beat
      end
    end
    @(negedge clk);
  endtask

  task automatic send_queue(input logic [SAMPLE_WIDTH-1:0] samples[$], input bit gaps,
                            output bit ok);
    int gap;
    ok = 1'b1;
    @(negedge clk);
    foreach (samples[i]) begin
      if (ok) begin
        if (gaps) begin
          gap = $urandom_range(2);
          axis.valid = 1'b0;
          repeat (gap) @(negedge clk);
        end
        send_beat(samples[i], i == samples.size() - 1, ok);
      end
    end
    axis.valid = 1'b0;
    axis.last  = 1'b0;
  endtask

endmodule

// File: tb/sample_capture_asserts.sv
// ********************
// bound checks on the capture top level
// output hold under stall, reset values, input ready when idle
// ********************

`timescale 1ns/1ps

module sample_capture_asserts (
  input logic                                clk,
  input logic                                reset_valid,
  input logic                                m_valid,
  input logic                                m_ready,
  input logic [capture_pkg::ENTRY_WIDTH-1:0] m_data,
  input logic                                m_last,
  input logic                                s_ready,
  input logic                                busy
);

  int fail_count = 0; // polled by the bench top

  // head entry must not move while the sink stalls
  a_stall_hold: assert property (@(posedge clk) disable iff (reset_valid)
    (m_valid && !m_ready) |=> (m_valid && $stable(m_data) && $stable(m_last)))
    else begin
      fail_count++;
      $error("m_axis valid, data or last changed while ready was low");
    end

  a_reset_out: assert property (@(posedge clk)
    reset_valid |=> (!m_valid && !busy && s_ready))
    else begin
      fail_count++;
      $error("outputs not at reset values in the cycle after reset");
    end

  // idle with an empty FIFO, input must be accepted
  a_idle_ready: assert property (@(posedge clk) disable iff (reset_valid)
    (!busy && !m_valid) |-> s_ready)
    else begin
      fail_count++;
      $error("s_axis ready low while idle with an empty FIFO");
    end

endmodule

bind sample_capture_top sample_capture_asserts asrt0 (
  .clk         (clk),
  .reset_valid (reset_valid),
  .m_valid     (m_axis.valid),
  .m_ready     (m_axis.ready),
  .m_data      (m_axis.data),
  .m_last      (m_axis.last),
  .s_ready     (s_axis.ready),
  .busy        (capture_busy)
);

// File: tb/sample_capture_tb.sv
// ********************
// testbench for the sample capture top level
// clock, reset, register writes, reference model, output monitor, tests
// ********************

`timescale 1ns/1ps

module sample_capture_tb;

  import capture_pkg::*;

  localparam int FIFO_DEPTH = 16;
  localparam int WAIT_LIMIT = 4000;

  typedef logic [SAMPLE_WIDTH-1:0] sample_q_t[$];

  logic           clk = 1'b0;
  logic           reset_valid;
  reg_write_t     reg_wr;
  logic           capture_busy;
  int             ready_pct;     // chance of m_axis.ready in percent
  capture_entry_t expected[$];

  Axis_If #(.DWIDTH(SAMPLE_WIDTH)) s_axis_if ();
  Axis_If #(.DWIDTH(ENTRY_WIDTH))  m_axis_if ();

  sample_capture_top #(.FIFO_DEPTH(FIFO_DEPTH)) dut0 (
    .clk          (clk),
    .reset_valid  (reset_valid),
    .reg_wr       (reg_wr),
    .s_axis       (s_axis_if),
    .m_axis       (m_axis_if),
    .capture_busy (capture_busy)
  );

  axis_driver #(.WAIT_LIMIT(WAIT_LIMIT)) drv0 (.clk(clk), .axis(s_axis_if));

  always #50 clk = ~clk;

  task automatic abort_run(input string why);
    $display("tests failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run("output entry differs from the model");
    end
  endtask

  // ready for the next rising edge, then compare a transfer that will happen there
  always @(negedge clk) begin : monitor
    capture_entry_t exp_entry;
    if (dut0.asrt0.fail_count != 0) abort_run("a stream protocol assertion failed");
    m_axis_if.ready = $urandom_range(99) < ready_pct;
    if (!reset_valid && m_axis_if.valid && m_axis_if.ready) begin
      if (expected.size() == 0) begin
        abort_run("output entry appeared when none was expected");
      end else begin
        exp_entry = expected.pop_front();
        check_hex("m_axis.data", m_axis_if.data, {exp_entry.index, exp_entry.sample});
        check_hex("m_axis.last", {31'b0, m_axis_if.last}, {31'b0, exp_entry.last});
      end
    end
  end

  // span 0 gives the full signed range, otherwise -span .. +span
  function automatic sample_q_t random_samples(input int n, input int span);
    sample_q_t q;
    for (int i = 0; i < n; i++) begin
      if (span == 0) q.push_back(SAMPLE_WIDTH'($urandom));
      else q.push_back(SAMPLE_WIDTH'($urandom_range(2 * span)) - SAMPLE_WIDTH'(span));
    end
    return q;
  endfunction

  // kept means strictly above the threshold, last goes on the final kept one
  function automatic void build_expected(input sample_q_t samples, input int thr);
    capture_entry_t entry;
    int n_kept;
    int k;
    n_kept = 0;
    k = 0;
    foreach (samples[i]) if (int'($signed(samples[i])) > thr) n_kept++;
    foreach (samples[i]) begin
      if (int'($signed(samples[i])) > thr) begin
        k++;
        entry.last   = (k == n_kept);
        entry.index  = 16'(i);
        entry.sample = samples[i];
        expected.push_back(entry);
      end
    end
  endfunction

  task automatic write_reg(input reg_addr_e addr, input logic [31:0] data);
    reg_wr.valid = 1'b1;
    reg_wr.addr  = addr;
    reg_wr.data  = data;
    @(negedge clk);
    reg_wr = '0;
  endtask

  task automatic wait_for(input string what);
    int waited;
    waited = 0;
    while (what == "start" ? !capture_busy :
           what == "idle" ? capture_busy : (expected.size() != 0 || m_axis_if.valid)) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) abort_run({"timed out waiting for ", what});
    end
  endtask

  task automatic send_idle(input int n);
    bit ok;
    drv0.send_queue(random_samples(n, 0), 1'b1, ok);
    if (!ok) abort_run("input stream stalled while idle");
    repeat (40) @(negedge clk); // any entry in this window is a failure
  endtask

  task automatic run_capture(input int thr, input int len, input int span, input bit gaps,
                             input int pct);
    sample_q_t samples;
    bit ok;
    ready_pct = pct;
    samples = random_samples(len, span);
    build_expected(samples, thr);
    write_reg(ADDR_THRESHOLD, 32'(thr));
    write_reg(ADDR_LENGTH, 32'(len));
    write_reg(ADDR_CONTROL, 32'h1);
    wait_for("start");
    drv0.send_queue(samples, gaps, ok);
    if (!ok) abort_run("input stream stalled during a capture");
    wait_for("idle");
    wait_for("drain");
  endtask

  initial begin
    void'($urandom(32'h85a3));
    reset_valid = 1'b1;
    reg_wr = '0;
    m_axis_if.ready = 1'b0;
    ready_pct = 100;
    repeat (8) @(negedge clk);
    reset_valid = 1'b0;
    send_idle(16);                          // no start yet
    run_capture(1000, 64, 0, 1'b0, 100);    // continuous traffic
    run_capture(1000, 200, 0, 1'b1, 30);    // gaps and back-pressure
    send_idle(24);                          // input after the end of a capture
    run_capture(-500, 32, 1000, 1'b0, 60);  // signed threshold, index restarts
    run_capture(32767, 20, 0, 1'b1, 100);   // nothing kept
    repeat (40) @(negedge clk);
    $display("all tests passed");
    $finish;
  end

endmodule

// File: sim.f
design/capture_pkg.sv
design/axis_if.sv
design/capture_regs.sv
design/threshold_discriminator.sv
design/sample_fifo.sv
design/sample_capture_top.sv
tb/axis_driver.sv
tb/sample_capture_asserts.sv
tb/sample_capture_tb.sv

// File: Makefile
# Verilator build for the sample capture testbench

VERILATOR ?= verilator
TOP       ?= sample_capture_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0 -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS)

clean:
	rm -rf $(BUILD_DIR)
